/* core_commit.sv */
`timescale 1ns/1ps

module core_commit (
    input  logic              clock,
    input  logic              rst_n_i,
    input  logic              valid_i,
    input  rv_pkg::word_t     pc_i,
    input  rv_pkg::word_t     result_i,
    input  rv_pkg::word_t     next_pc_i,
    input  logic              we_i,
    input  rv_pkg::reg_addr_t rd_i,
    output logic              rf_we_o,
    output rv_pkg::reg_addr_t rf_rd_o,
    output rv_pkg::word_t     rf_wdata_o,
    output logic              redirect_valid_o,
    output rv_pkg::word_t     redirect_pc_o,
    output logic              retire_valid_o,
    output logic              retire_we_o,
    output rv_pkg::word_t     retire_pc_o,
    output rv_pkg::word_t     retire_wdata_o,
    output rv_pkg::reg_addr_t retire_rd_o
);
    import rv_pkg::*;

    logic      valid_q;
    logic      we_q;
    word_t     pc_q;
    word_t     result_q;
    word_t     next_pc_q;
    reg_addr_t rd_q;

    always_ff @(posedge clock) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clock) begin
        if (valid_i) begin
            we_q      <= we_i;
            pc_q      <= pc_i;
            result_q  <= result_i;
            next_pc_q <= next_pc_i;
            rd_q      <= rd_i;
        end
    end

    // write-back, retire and redirect all leave in one cycle.
    assign rf_we_o    = valid_q && we_q;
    assign rf_rd_o    = rd_q;
    assign rf_wdata_o = result_q;

    assign redirect_valid_o = valid_q;
    assign redirect_pc_o    = next_pc_q;

    assign retire_valid_o = valid_q;
    assign retire_we_o    = we_q;
    assign retire_pc_o    = pc_q;
    assign retire_wdata_o = result_q;
    assign retire_rd_o    = rd_q;

endmodule

/* core_decode.sv */
`timescale 1ns/1ps

module core_decode (
    input  logic              clock,
    input  logic              rst_n_i,
    input  logic              valid_i,
    input  rv_pkg::word_t     pc_i,
    input  rv_pkg::word_t     inst_i,
    input  rv_pkg::word_t     rs1_data_i,
    input  rv_pkg::word_t     rs2_data_i,
    output rv_pkg::reg_addr_t rs1_o,
    output rv_pkg::reg_addr_t rs2_o,
    output logic              valid_o,
    output rv_pkg::word_t     pc_o,
    output rv_pkg::word_t     op_a_o,
    output rv_pkg::word_t     op_b_o,
    output rv_pkg::word_t     imm_o,
    output rv_pkg::alu_op_e   alu_op_o,
    output rv_pkg::br_op_e    br_op_o,
    output logic              we_o,
    output rv_pkg::reg_addr_t rd_o
);
    import rv_pkg::*;

    rv_inst_u   inst;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;
    word_t      imm_d;
    word_t      op_a_d;
    word_t      op_b_d;
    alu_op_e    alu_op_d;
    br_op_e     br_op_d;
    logic       we_d;

    assign inst   = inst_i;
    assign opcode = inst.r.opcode;
    assign funct3 = inst.r.funct3;
    // bit 30, picks sub and sra.
    assign alt    = inst.r.funct7[5];

    assign rs1_o = inst.r.rs1;
    assign rs2_o = inst.r.rs2;

    always_comb begin
        case (opcode)
            OPC_OP_IMM, OPC_JALR: imm_d = {{20{inst.i.imm[11]}}, inst.i.imm};
            OPC_BRANCH: imm_d = {{20{inst.b.imm12}}, inst.b.imm11, inst.b.imm10_5,
                                 inst.b.imm4_1, 1'b0};
            OPC_LUI, OPC_AUIPC: imm_d = {inst.j.imm20, inst.j.imm10_1, inst.j.imm11,
                                         inst.j.imm19_12, 12'b0};
            OPC_JAL: imm_d = {{12{inst.j.imm20}}, inst.j.imm19_12, inst.j.imm11,
                              inst.j.imm10_1, 1'b0};
            default: imm_d = '0;
        endcase
    end

    always_comb begin
        alu_op_d = ALU_ADD;
        br_op_d  = BR_NONE;
        if ((opcode == OPC_OP) || (opcode == OPC_OP_IMM)) begin
            case (funct3)
                F3_ADD:  alu_op_d = ((opcode == OPC_OP) && alt) ? ALU_SUB : ALU_ADD;
                F3_SLL:  alu_op_d = ALU_SLL;
                F3_SLT:  alu_op_d = ALU_SLT;
                F3_SLTU: alu_op_d = ALU_SLTU;
                F3_XOR:  alu_op_d = ALU_XOR;
                F3_SR:   alu_op_d = alt ? ALU_SRA : ALU_SRL;
                F3_OR:   alu_op_d = ALU_OR;
                F3_AND:  alu_op_d = ALU_AND;
            endcase
        end else if (opcode == OPC_LUI) begin
            alu_op_d = ALU_PASS;
        end else if (opcode == OPC_BRANCH) begin
            case (funct3)
                F3_BEQ:  br_op_d = BR_EQ;
                F3_BNE:  br_op_d = BR_NE;
                F3_BLT:  br_op_d = BR_LT;
                F3_BGE:  br_op_d = BR_GE;
                F3_BLTU: br_op_d = BR_LTU;
                F3_BGEU: br_op_d = BR_GEU;
                default: br_op_d = BR_NONE;
            endcase
        end else if (opcode == OPC_JAL) begin
            br_op_d = BR_JAL;
        end else if (opcode == OPC_JALR) begin
            br_op_d = BR_JALR;
        end
    end

    // op_b is the second alu operand, or rs1 for jalr.
    always_comb begin
        op_a_d = rs1_data_i;
        op_b_d = imm_d;
        we_d   = (inst.r.rd != '0);
        case (opcode)
            OPC_OP, OPC_BRANCH: op_b_d = rs2_data_i;
            OPC_AUIPC, OPC_JAL: op_a_d = pc_i;
            OPC_JALR: begin
                op_a_d = pc_i;
                op_b_d = rs1_data_i;
            end
            OPC_OP_IMM, OPC_LUI: op_b_d = imm_d;
            default: we_d = 1'b0;
        endcase
        if (opcode == OPC_BRANCH) begin
            we_d = 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clock) begin
        if (valid_i) begin
            pc_o     <= pc_i;
            op_a_o   <= op_a_d;
            op_b_o   <= op_b_d;
            imm_o    <= imm_d;
            alu_op_o <= alu_op_d;
            br_op_o  <= br_op_d;
            we_o     <= we_d;
            rd_o     <= inst.r.rd;
        end
    end

endmodule

/* core_execute.sv */
`timescale 1ns/1ps

module core_execute (
    input  logic              clock,
    input  logic              rst_n_i,
    input  logic              valid_i,
    input  rv_pkg::word_t     pc_i,
    input  rv_pkg::word_t     op_a_i,
    input  rv_pkg::word_t     op_b_i,
    input  rv_pkg::word_t     imm_i,
    input  rv_pkg::alu_op_e   alu_op_i,
    input  rv_pkg::br_op_e    br_op_i,
    input  logic              we_i,
    input  rv_pkg::reg_addr_t rd_i,
    output logic              valid_o,
    output rv_pkg::word_t     pc_o,
    output rv_pkg::word_t     result_o,
    output rv_pkg::word_t     next_pc_o,
    output logic              we_o,
    output rv_pkg::reg_addr_t rd_o
);
    import rv_pkg::*;

    localparam int SHW = $clog2(XLEN);

    word_t          alu_res;
    word_t          pc_plus4;
    word_t          target;
    logic           take;
    logic           jump;
    logic [SHW-1:0] shamt;

    // ====================================================================
    // alu.
    // ====================================================================
    assign shamt = op_b_i[SHW-1:0];

    always_comb begin
        case (alu_op_i)
            ALU_ADD:  alu_res = op_a_i + op_b_i;
            ALU_SUB:  alu_res = op_a_i - op_b_i;
            ALU_AND:  alu_res = op_a_i & op_b_i;
            ALU_OR:   alu_res = op_a_i | op_b_i;
            ALU_XOR:  alu_res = op_a_i ^ op_b_i;
            ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, $signed(op_a_i) < $signed(op_b_i)};
            ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, op_a_i < op_b_i};
            ALU_SLL:  alu_res = op_a_i << shamt;
            ALU_SRL:  alu_res = op_a_i >> shamt;
            ALU_SRA:  alu_res = word_t'($signed(op_a_i) >>> shamt);
            // lui.
            default:  alu_res = imm_i;
        endcase
    end

    // ====================================================================
    // branch and next pc.
    // ====================================================================
    always_comb begin
        case (br_op_i)
            BR_EQ:   take = (op_a_i == op_b_i);
            BR_NE:   take = (op_a_i != op_b_i);
            BR_LT:   take = ($signed(op_a_i) < $signed(op_b_i));
            BR_GE:   take = ($signed(op_a_i) >= $signed(op_b_i));
            BR_LTU:  take = (op_a_i < op_b_i);
            BR_GEU:  take = (op_a_i >= op_b_i);
            BR_JAL:  take = 1'b1;
            BR_JALR: take = 1'b1;
            default: take = 1'b0;
        endcase
    end

    assign jump     = (br_op_i == BR_JAL) || (br_op_i == BR_JALR);
    assign pc_plus4 = pc_i + word_t'(4);

    // jalr base is rs1, carried on op_b.
    assign target = (br_op_i == BR_JALR) ? ((op_b_i + imm_i) & ~word_t'(1))
                                         : (pc_i + imm_i);

    always_ff @(posedge clock) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clock) begin
        if (valid_i) begin
            pc_o      <= pc_i;
            result_o  <= jump ? pc_plus4 : alu_res;
            next_pc_o <= take ? target : pc_plus4;
            we_o      <= we_i;
            rd_o      <= rd_i;
        end
    end

endmodule

/* core_fetch.sv */
`timescale 1ns/1ps

module core_fetch #(
    parameter rv_pkg::word_t RESET_PC = '0
) (
    input  logic          clock,
    input  logic          rst_n_i,
    input  logic          redirect_valid_i,
    input  rv_pkg::word_t redirect_pc_i,
    input  logic          imem_rvalid_i,
    input  rv_pkg::word_t imem_rdata_i,
    output logic          imem_req_o,
    output rv_pkg::word_t imem_addr_o,
    output logic          valid_o,
    output rv_pkg::word_t pc_o,
    output rv_pkg::word_t inst_o
);
    import rv_pkg::*;

    localparam logic [1:0] ST_REQ  = 2'd0;
    localparam logic [1:0] ST_WAIT = 2'd1;
    localparam logic [1:0] ST_IDLE = 2'd2;

    logic [1:0] state_q;
    logic       start_q;
    word_t      pc_q;

    always_ff @(posedge clock) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
            start_q <= 1'b1;
            pc_q    <= RESET_PC;
        end else begin
            start_q <= 1'b0;
            case (state_q)
                ST_REQ: begin
                    state_q <= ST_WAIT;
                end
                ST_WAIT: begin
                    // memory may take any number of cycles.
                    if (imem_rvalid_i) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: begin
                    if (redirect_valid_i) begin
                        state_q <= ST_REQ;
                        pc_q    <= redirect_pc_i;
                    end else if (start_q) begin
                        // first fetch out of reset.
                        state_q <= ST_REQ;
                    end
                end
            endcase
        end
    end

    assign imem_req_o  = (state_q == ST_REQ);
    assign imem_addr_o = pc_q;

    // response goes straight on to the decode register.
    assign valid_o = (state_q == ST_WAIT) && imem_rvalid_i;
    assign pc_o    = pc_q;
    assign inst_o  = imem_rdata_i;

endmodule

/* core_regfile.sv */
`timescale 1ns/1ps

module core_regfile (
    input  logic              clock,
    input  rv_pkg::reg_addr_t rs1_i,
    input  rv_pkg::reg_addr_t rs2_i,
    input  logic              we_i,
    input  rv_pkg::reg_addr_t rd_i,
    input  rv_pkg::word_t     wdata_i,
    output rv_pkg::word_t     rs1_data_o,
    output rv_pkg::word_t     rs2_data_o
);
    import rv_pkg::*;

    // x0 has no storage.
    word_t regs [1:31];

    always_ff @(posedge clock) begin
        if (we_i && (rd_i != '0)) begin
            regs[rd_i] <= wdata_i;
        end
    end

    assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

/* project.f */
rv_pkg.sv
core_fetch.sv
core_regfile.sv
core_decode.sv
core_execute.sv
core_commit.sv
rv_core.sv
tb_rv_core.sv

/* rv_core.sv */
`timescale 1ns/1ps

module rv_core #(
    parameter rv_pkg::word_t RESET_PC = '0
) (
    input  logic              clock,
    input  logic              rst_n_i,
    input  logic              imem_rvalid_i,
    input  rv_pkg::word_t     imem_rdata_i,
    output logic              imem_req_o,
    output rv_pkg::word_t     imem_addr_o,
    output logic              retire_valid_o,
    output logic              retire_we_o,
    output rv_pkg::word_t     retire_pc_o,
    output rv_pkg::reg_addr_t retire_rd_o,
    output rv_pkg::word_t     retire_wdata_o
);
    import rv_pkg::*;

    // fetch to decode.
    logic      f_valid;
    word_t     f_pc;
    word_t     f_inst;

    // decode and register file.
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     rs1_data;
    word_t     rs2_data;

    // decode to execute.
    logic      d_valid;
    word_t     d_pc;
    word_t     d_op_a;
    word_t     d_op_b;
    word_t     d_imm;
    alu_op_e   d_alu_op;
    br_op_e    d_br_op;
    logic      d_we;
    reg_addr_t d_rd;

    // execute to commit.
    logic      e_valid;
    word_t     e_pc;
    word_t     e_result;
    word_t     e_next_pc;
    logic      e_we;
    reg_addr_t e_rd;

    // commit to fetch and register file.
    logic      c_redirect_valid;
    word_t     c_redirect_pc;
    logic      c_rf_we;
    reg_addr_t c_rf_rd;
    word_t     c_rf_wdata;

    core_fetch #(
        .RESET_PC (RESET_PC)
    ) i_fetch (
        .clock            (clock),
        .rst_n_i          (rst_n_i),
        .redirect_valid_i (c_redirect_valid),
        .redirect_pc_i    (c_redirect_pc),
        .imem_rvalid_i    (imem_rvalid_i),
        .imem_rdata_i     (imem_rdata_i),
        .imem_req_o       (imem_req_o),
        .imem_addr_o      (imem_addr_o),
        .valid_o          (f_valid),
        .pc_o             (f_pc),
        .inst_o           (f_inst)
    );

    core_regfile i_regfile (
        .clock      (clock),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .we_i       (c_rf_we),
        .rd_i       (c_rf_rd),
        .wdata_i    (c_rf_wdata),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    core_decode i_decode (
        .clock      (clock),
        .rst_n_i    (rst_n_i),
        .valid_i    (f_valid),
        .pc_i       (f_pc),
        .inst_i     (f_inst),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .rs1_o      (rs1),
        .rs2_o      (rs2),
        .valid_o    (d_valid),
        .pc_o       (d_pc),
        .op_a_o     (d_op_a),
        .op_b_o     (d_op_b),
        .imm_o      (d_imm),
        .alu_op_o   (d_alu_op),
        .br_op_o    (d_br_op),
        .we_o       (d_we),
        .rd_o       (d_rd)
    );

    core_execute i_execute (
        .clock     (clock),
        .rst_n_i   (rst_n_i),
        .valid_i   (d_valid),
        .pc_i      (d_pc),
        .op_a_i    (d_op_a),
        .op_b_i    (d_op_b),
        .imm_i     (d_imm),
        .alu_op_i  (d_alu_op),
        .br_op_i   (d_br_op),
        .we_i      (d_we),
        .rd_i      (d_rd),
        .valid_o   (e_valid),
        .pc_o      (e_pc),
        .result_o  (e_result),
        .next_pc_o (e_next_pc),
        .we_o      (e_we),
        .rd_o      (e_rd)
    );

    core_commit i_commit (
        .clock            (clock),
        .rst_n_i          (rst_n_i),
        .valid_i          (e_valid),
        .pc_i             (e_pc),
        .result_i         (e_result),
        .next_pc_i        (e_next_pc),
        .we_i             (e_we),
        .rd_i             (e_rd),
        .rf_we_o          (c_rf_we),
        .rf_rd_o          (c_rf_rd),
        .rf_wdata_o       (c_rf_wdata),
        .redirect_valid_o (c_redirect_valid),
        .redirect_pc_o    (c_redirect_pc),
        .retire_valid_o   (retire_valid_o),
        .retire_we_o      (retire_we_o),
        .retire_pc_o      (retire_pc_o),
        .retire_wdata_o   (retire_wdata_o),
        .retire_rd_o      (retire_rd_o)
    );

endmodule

/* rv_core_testdata.txt */
// hex counts. program: word count, then words from address 0.
// trace: retire count, then lines of pc, we, rd, wdata (rd and wdata unused when we is 0).
28
FFB00093 // 00 addi x1, x0, -5
00300113 // 04 addi x2, x0, 3
002081B3 // 08 add  x3, x1, x2
40110233 // 0c sub  x4, x2, x1
0020A2B3 // 10 slt  x5, x1, x2
0020B333 // 14 sltu x6, x1, x2
4020D3B3 // 18 sra  x7, x1, x2
01F0D413 // 1c srli x8, x1, 31
01F11493 // 20 slli x9, x2, 31
0020C533 // 24 xor  x10, x1, x2
FF016593 // 28 ori  x11, x2, -16
00F0F613 // 2c andi x12, x1, 15
41F4D693 // 30 srai x13, x9, 31
ABCDE737 // 34 lui  x14, 0xabcde
00001797 // 38 auipc x15, 0x1
00208463 // 3c beq  x1, x2, +8  not taken
00209463 // 40 bne  x1, x2, +8  taken
FFF00F93 // 44 skipped
0020C463 // 48 blt  x1, x2, +8  taken
FFF00F93 // 4c skipped
0020E463 // 50 bltu x1, x2, +8  not taken
0020D463 // 54 bge  x1, x2, +8  not taken
0020F463 // 58 bgeu x1, x2, +8  taken
FFF00F93 // 5c skipped
00210463 // 60 beq  x2, x2, +8  taken
FFF00F93 // 64 skipped
00211463 // 68 bne  x2, x2, +8  not taken
00115463 // 6c bge  x2, x1, +8  taken
FFF00F93 // 70 skipped
00116463 // 74 bltu x2, x1, +8  taken
FFF00F93 // 78 skipped
00114463 // 7c blt  x2, x1, +8  not taken
00117463 // 80 bgeu x2, x1, +8  not taken
0080086F // 84 jal  x16, +8
FFF00F93 // 88 skipped
00D808E7 // 8c jalr x17, 13(x16)
FFF00F93 // 90 skipped
00708013 // 94 addi x0, x1, 7
00200933 // 98 add  x18, x0, x2
0000006F // 9c jal  x0, 0
20
00000000 1 01 FFFFFFFB
00000004 1 02 00000003
00000008 1 03 FFFFFFFE
0000000C 1 04 00000008
00000010 1 05 00000001
00000014 1 06 00000000
00000018 1 07 FFFFFFFF
0000001C 1 08 00000001
00000020 1 09 80000000
00000024 1 0A FFFFFFF8
00000028 1 0B FFFFFFF3
0000002C 1 0C 0000000B
00000030 1 0D FFFFFFFF
00000034 1 0E ABCDE000
00000038 1 0F 00001038
0000003C 0 00 00000000
00000040 0 00 00000000
00000048 0 00 00000000
00000050 0 00 00000000
00000054 0 00 00000000
00000058 0 00 00000000
00000060 0 00 00000000
00000068 0 00 00000000
0000006C 0 00 00000000
00000074 0 00 00000000
0000007C 0 00 00000000
00000080 0 00 00000000
00000084 1 10 00000088
0000008C 1 11 00000090
00000094 0 00 00000000
00000098 1 12 00000003
0000009C 0 00 00000000

/* rv_pkg.sv */
package rv_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    // major opcodes.
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // funct3, alu group.
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // funct3, branch group.
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT,
        ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_PASS
    } alu_op_e;

    // nine kinds, so one bit wider than the six compares need.
    typedef enum logic [3:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JAL, BR_JALR
    } br_op_e;

    // ====================================================================
    // instruction format views.
    // ====================================================================
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    // the u immediate is bits 31:12 of this view.
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        b_fmt_t b;
        j_fmt_t j;
    } rv_inst_u;

endpackage

/* tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core;
    import rv_pkg::*;

    localparam int    RESET_CYCLES = 5;
    localparam int    MEM_WORDS    = 256;
    localparam int    MAX_RETIRE   = 128;
    localparam int    FILE_WORDS   = 2 + MEM_WORDS + 4 * MAX_RETIRE;
    localparam word_t START_PC     = 32'h0000_0000;
    localparam word_t FILL_BASE    = 32'hdead_0000;

    logic      clock;
    logic      rst_n_i;
    logic      imem_rvalid_i;
    word_t     imem_rdata_i;
    logic      imem_req_o;
    word_t     imem_addr_o;
    logic      retire_valid_o;
    logic      retire_we_o;
    word_t     retire_pc_o;
    reg_addr_t retire_rd_o;
    word_t     retire_wdata_o;

    word_t     file_words [0:FILE_WORDS-1];
    word_t     imem       [0:MEM_WORDS-1];
    word_t     exp_pc     [0:MAX_RETIRE-1];
    logic      exp_we     [0:MAX_RETIRE-1];
    reg_addr_t exp_rd     [0:MAX_RETIRE-1];
    word_t     exp_wdata  [0:MAX_RETIRE-1];

    int prog_count;
    int retire_count;
    int retire_idx;
    int cyc;
    int req_due;
    int rvalid_cyc;
    int cycle_limit;

    logic [31:0] lfsr_q;
    logic        mem_busy;
    int          mem_delay;
    word_t       mem_addr;

    rv_core #(
        .RESET_PC (START_PC)
    ) i_dut (
        .clock          (clock),
        .rst_n_i        (rst_n_i),
        .imem_rvalid_i  (imem_rvalid_i),
        .imem_rdata_i   (imem_rdata_i),
        .imem_req_o     (imem_req_o),
        .imem_addr_o    (imem_addr_o),
        .retire_valid_o (retire_valid_o),
        .retire_we_o    (retire_we_o),
        .retire_pc_o    (retire_pc_o),
        .retire_rd_o    (retire_rd_o),
        .retire_wdata_o (retire_wdata_o)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // ====================================================================
    // helpers.
    // ====================================================================
    // galois form, x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    function automatic word_t word_at(input word_t addr);
        word_t idx;
        idx = addr >> 2;
        if (idx < MEM_WORDS) begin
            return imem[idx];
        end
        return FILL_BASE ^ addr;
    endfunction

    function automatic string inst_kind(input word_t inst);
        case (inst[6:0])
            OPC_OP:     return "alu reg";
            OPC_OP_IMM: return "alu imm";
            OPC_LUI:    return "lui";
            OPC_AUIPC:  return "auipc";
            OPC_JAL:    return "jal";
            OPC_JALR:   return "jalr";
            OPC_BRANCH: return "branch";
            default:    return "unknown";
        endcase
    endfunction

    task automatic value_error(input string name, input word_t expected, input word_t actual);
        $display("** Error: %s: expected %h, actual %h", name, expected, actual);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic abort_run(input string what);
        $display("error: %s", what);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic load_testdata();
        int pos;
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = FILL_BASE ^ word_t'(i * 4);
        end
        $readmemh("rv_core_testdata.txt", file_words);
        assert (!$isunknown(file_words[0])) else abort_run("test data file missing or empty");
        prog_count = int'(file_words[0]);
        assert (prog_count <= MEM_WORDS) else abort_run("program does not fit the memory model");
        for (int i = 0; i < prog_count; i++) begin
            imem[i] = file_words[1 + i];
        end
        pos          = 1 + prog_count;
        retire_count = int'(file_words[pos]);
        assert ((retire_count > 0) && (retire_count <= MAX_RETIRE))
            else abort_run("retire count in test data is out of range");
        pos = pos + 1;
        for (int i = 0; i < retire_count; i++) begin
            exp_pc[i]    = file_words[pos];
            exp_we[i]    = file_words[pos + 1][0];
            exp_rd[i]    = file_words[pos + 2][4:0];
            exp_wdata[i] = file_words[pos + 3];
            pos          = pos + 4;
        end
        assert (!$isunknown(exp_wdata[retire_count - 1])) else abort_run("test data ends early");
    endtask

    // one request per retire, exactly one cycle later.
    task automatic watch_fetch();
        logic  due;
        word_t exp_addr;
        due      = (cyc == req_due);
        exp_addr = (retire_idx == 0) ? START_PC : exp_pc[retire_idx];
        assert (imem_req_o === due)
            else value_error($sformatf("fetch request in cycle %0d", cyc),
                             word_t'(due), word_t'(imem_req_o));
        if (due) begin
            assert (imem_addr_o == exp_addr)
                else value_error($sformatf("fetch address before retire %0d", retire_idx),
                                 exp_addr, imem_addr_o);
        end
    endtask

    task automatic compare_retire();
        string name;
        name = $sformatf("retire %0d (%s at %h)", retire_idx,
                         inst_kind(word_at(exp_pc[retire_idx])), exp_pc[retire_idx]);
        assert (cyc > RESET_CYCLES + 1) else abort_run("retire_valid_o was high during reset");
        assert (rvalid_cyc >= 0) else abort_run("retire_valid_o rose before any memory response");
        assert (cyc == rvalid_cyc + 3)
            else value_error({name, " cycles after response"}, word_t'(3),
                             word_t'(cyc - rvalid_cyc));
        assert (retire_pc_o == exp_pc[retire_idx])
            else value_error({name, " pc"}, exp_pc[retire_idx], retire_pc_o);
        assert (retire_we_o === exp_we[retire_idx])
            else value_error({name, " we"}, word_t'(exp_we[retire_idx]), word_t'(retire_we_o));
        if (exp_we[retire_idx]) begin
            assert (retire_rd_o == exp_rd[retire_idx])
                else value_error({name, " rd"}, word_t'(exp_rd[retire_idx]),
                                 word_t'(retire_rd_o));
            assert (retire_wdata_o == exp_wdata[retire_idx])
                else value_error({name, " wdata"}, exp_wdata[retire_idx], retire_wdata_o);
        end
        req_due    = cyc + 1;
        retire_idx = retire_idx + 1;
    endtask

    // ====================================================================
    // memory model, 1 to 4 cycles per read.
    // ====================================================================
    always @(posedge clock) begin : memory_model
        logic bit_lo;
        logic bit_hi;
        imem_rvalid_i <= 1'b0;
        if (!rst_n_i) begin
            mem_busy = 1'b0;
        end else begin
            if (imem_req_o === 1'b1) begin
                bit_lo    = lfsr_q[0];
                lfsr_q    = lfsr_next(lfsr_q);
                bit_hi    = lfsr_q[0];
                lfsr_q    = lfsr_next(lfsr_q);
                mem_delay = 1 + int'({bit_hi, bit_lo});
                mem_addr  = imem_addr_o;
                mem_busy  = 1'b1;
            end
            if (mem_busy) begin
                if (mem_delay == 1) begin
                    imem_rvalid_i <= 1'b1;
                    imem_rdata_i  <= word_at(mem_addr);
                    mem_busy = 1'b0;
                end else begin
                    mem_delay = mem_delay - 1;
                end
            end
        end
    end

    initial begin
        rst_n_i       = 1'b0;
        imem_rvalid_i = 1'b0;
        imem_rdata_i  = '0;
        lfsr_q        = 32'h3822;
        cyc           = 0;
        retire_idx    = 0;
        rvalid_cyc    = -1;
        // reset, then one quiet cycle, then the first request.
        req_due       = RESET_CYCLES + 2;
        load_testdata();
        cycle_limit = 20 + 10 * retire_count + 50;

        while ((retire_idx < retire_count) && (cyc < cycle_limit)) begin
            @(posedge clock);
            cyc = cyc + 1;
            if (cyc == RESET_CYCLES) begin
                rst_n_i <= 1'b1;
            end
            if (imem_rvalid_i === 1'b1) begin
                rvalid_cyc = cyc;
            end
            // outputs are unknown before the first reset edge.
            if (cyc > 1) begin
                watch_fetch();
            end
            if (retire_valid_o === 1'b1) begin
                compare_retire();
            end
        end

        if (retire_idx == retire_count) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("timeout: %0d of %0d retires seen after %0d cycles",
                     retire_idx, retire_count, cyc);
            $display("TESTBENCH FAILED");
            $fatal(1, "cycle limit reached");
        end
    end

endmodule
